// ==== Bender.yml ====
package:
  name: analog_top

sources:
  - logic/analog_pkg.sv
  - logic/ams_regs.sv
  - logic/adc_frontend.sv
  - logic/dac_output_stage.sv
  - logic/pdm_modulator.sv
  - logic/analog_top.sv
  - target: test
    files:
      - test/tb_analog_top.sv

// ==== flist.f ====
logic/analog_pkg.sv
logic/ams_regs.sv
logic/adc_frontend.sv
logic/dac_output_stage.sv
logic/pdm_modulator.sv
logic/analog_top.sv
test/tb_analog_top.sv

// ==== logic/adc_frontend.sv ====
// ADC front end
// Negative-slope ADC words to two's complement, with digital loopback

`timescale 1ns/1ps
`default_nettype none

module adc_frontend import analog_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n_i,        // async, active low
  input  logic [ADC_W-1:0] adc_raw_a_i,    // raw ADC word, channel A
  input  logic [ADC_W-1:0] adc_raw_b_i,    // raw ADC word, channel B
  input  logic             digital_loop_i, // select DAC samples
  input  dac_sample_t      loop_a_i,       // saturated DAC sample A
  input  dac_sample_t      loop_b_i,       // saturated DAC sample B
  output adc_sample_t      adc_a_o,
  output adc_sample_t      adc_b_o
);

  // Keep MSB, invert the rest
  function automatic adc_sample_t adc_to_twos(input logic [ADC_W-1:0] raw);
    return {raw[ADC_W-1], ~raw[ADC_W-2:0]};
  endfunction

  // Loop sample sits in the low bits, upper bits zero (not sign extended)
  function automatic adc_sample_t loop_pad(input dac_sample_t smp);
    return {{(ADC_W-DAC_W){1'b0}}, smp};
  endfunction

  // One register stage for both sources
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= digital_loop_i ? loop_pad(loop_a_i) : adc_to_twos(adc_raw_a_i);
      adc_b_o <= digital_loop_i ? loop_pad(loop_b_i) : adc_to_twos(adc_raw_b_i);
    end
  end

endmodule : adc_frontend

`default_nettype wire

// ==== logic/ams_regs.sv ====
// Analog configuration registers
// APB slave with the digital loopback bit and the PDM output levels

`timescale 1ns/1ps
`default_nettype none

module ams_regs import analog_pkg::*; #(
  parameter int unsigned NUM_PDM = 4        // number of PDM channels
) (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,       // async, active low
  // APB slave
  input  logic [APB_AW-1:0]        paddr_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [31:0]              pwdata_i,
  output logic [31:0]              prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  // Configuration outputs
  output logic                     digital_loop_o,  // ADC replaced by DAC
  output logic [NUM_PDM*PDM_W-1:0] pdm_level_o      // packed PDM levels
);

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  logic                             access;    // APB access phase
  logic                             ctrl_hit;
  logic                             pdm_hit;
  logic [APB_AW-1:0]                pdm_off;   // offset from first level reg
  logic [APB_AW-3:0]                pdm_idx;   // level register index
  logic                             digital_loop_q;
  logic [NUM_PDM-1:0][PDM_W-1:0]    pdm_level_q;

  assign access   = psel_i & penable_i;
  assign ctrl_hit = (paddr_i == REG_CTRL);

  assign pdm_off = paddr_i - REG_PDM_BASE;
  assign pdm_idx = pdm_off[APB_AW-1:2];     // word index
  assign pdm_hit = (paddr_i >= REG_PDM_BASE)
                && (pdm_off[1:0] == 2'b00)   // word aligned only
                && (pdm_idx < NUM_PDM);

  // No wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~(ctrl_hit | pdm_hit);  // unmapped offset

  ////////////////////////////////////////////////////////////////////////////
  // Register write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      digital_loop_q <= 1'b0;             // loop off
      pdm_level_q    <= '0;               // all PDM outputs low
    end else if (access && pwrite_i) begin
      if (ctrl_hit)
        digital_loop_q <= pwdata_i[0];
      if (pdm_hit)
        pdm_level_q[pdm_idx] <= pwdata_i[PDM_W-1:0];
    end
  end

  // Read mux, zero extended
  always_comb begin
    prdata_o = '0;                        // unmapped reads return zero
    if (ctrl_hit) begin
      prdata_o[0] = digital_loop_q;
    end else if (pdm_hit) begin
      prdata_o[PDM_W-1:0] = pdm_level_q[pdm_idx];
    end
  end

  assign digital_loop_o = digital_loop_q;
  assign pdm_level_o    = pdm_level_q;    // channel 0 in the low byte

endmodule : ams_regs

`default_nettype wire

// ==== logic/analog_pkg.sv ====
// Analog sample path definitions
// Sample widths and types, PDM width and register map shared by the RTL

`default_nettype none

package analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sample widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_W = 16;  // ADC word, 16 bit converter
  localparam int unsigned DAC_W = 14;  // DAC word, 14 bit converter
  localparam int unsigned PDM_W = 8;   // PDM level and accumulator width

  // Two's complement samples after format conversion
  typedef logic signed [ADC_W-1:0] adc_sample_t;  // acquire side
  typedef logic signed [DAC_W-1:0] dac_sample_t;  // generate side

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned APB_AW = 8;  // APB address width

  // Control register
  // bit 0 digital loop, others read zero
  localparam logic [APB_AW-1:0] REG_CTRL = 8'h00;

  // First PDM level register
  // channel k lives at REG_PDM_BASE + 4*k
  localparam logic [APB_AW-1:0] REG_PDM_BASE = 8'h04;

endpackage : analog_pkg

`default_nettype wire

// ==== logic/analog_top.sv ====
// Analog sample path top
// Register block, ADC front end, DAC output stage and PDM outputs

`timescale 1ns/1ps
`default_nettype none

module analog_top import analog_pkg::*; #(
  parameter int unsigned NUM_PDM = 4        // slow analog outputs
) (
  input  logic               adc_clk,
  input  logic               rst_n_i,       // async, active low
  // APB slave
  input  logic [APB_AW-1:0]  paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  // ADC
  input  logic [ADC_W-1:0]   adc_raw_a_i,   // negative-slope words
  input  logic [ADC_W-1:0]   adc_raw_b_i,
  output adc_sample_t        adc_a_o,       // two's complement
  output adc_sample_t        adc_b_o,
  // DAC sources
  input  dac_sample_t        asg_a_i,       // generator
  input  dac_sample_t        asg_b_i,
  input  dac_sample_t        pid_a_i,       // controller
  input  dac_sample_t        pid_b_i,
  // DAC codes, one per channel
  output logic [DAC_W-1:0]   dac_code_a_o,
  output logic [DAC_W-1:0]   dac_code_b_o,
  // PDM
  output logic [NUM_PDM-1:0] pdm_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Local signals
  ////////////////////////////////////////////////////////////////////////////

  logic                     digital_loop;  // loopback select
  logic [NUM_PDM*PDM_W-1:0] pdm_level;     // packed PDM levels
  dac_sample_t              sat_a;         // saturated DAC samples
  dac_sample_t              sat_b;

  // Configuration
  ams_regs #(
    .NUM_PDM (NUM_PDM)
  ) u_regs (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .paddr_i        (paddr_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .digital_loop_o (digital_loop),
    .pdm_level_o    (pdm_level)
  );

  // Stage 1
  adc_frontend u_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_raw_a_i    (adc_raw_a_i),
    .adc_raw_b_i    (adc_raw_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (sat_a),               // same cycle as DAC sum
    .loop_b_i       (sat_b),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  // Stage 2
  dac_output_stage u_dac (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .asg_a_i      (asg_a_i),
    .asg_b_i      (asg_b_i),
    .pid_a_i      (pid_a_i),
    .pid_b_i      (pid_b_i),
    .sat_a_o      (sat_a),
    .sat_b_o      (sat_b),
    .dac_code_a_o (dac_code_a_o),
    .dac_code_b_o (dac_code_b_o)
  );

  // Slow analog outputs
  pdm_modulator #(
    .NUM_PDM (NUM_PDM)
  ) u_pdm (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .pdm_level_i (pdm_level),
    .pdm_o       (pdm_o)
  );

endmodule : analog_top

`default_nettype wire

// ==== logic/dac_output_stage.sv ====
// DAC output stage
// Generator plus PID sum, 14 bit saturation and negative-slope DAC code

`timescale 1ns/1ps
`default_nettype none

module dac_output_stage import analog_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n_i,       // async, active low
  input  dac_sample_t      asg_a_i,       // generator, channel A
  input  dac_sample_t      asg_b_i,       // generator, channel B
  input  dac_sample_t      pid_a_i,       // controller, channel A
  input  dac_sample_t      pid_b_i,       // controller, channel B
  output dac_sample_t      sat_a_o,       // saturated sum A, combinational
  output dac_sample_t      sat_b_o,       // saturated sum B, combinational
  output logic [DAC_W-1:0] dac_code_a_o,  // registered DAC code A
  output logic [DAC_W-1:0] dac_code_b_o   // registered DAC code B
);

  ////////////////////////////////////////////////////////////////////////////
  // Sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  logic signed [DAC_W:0] sum_a;  // one guard bit
  logic signed [DAC_W:0] sum_b;

  assign sum_a = asg_a_i + pid_a_i;  // operands sign extended to 15 bits
  assign sum_b = asg_b_i + pid_b_i;

  // Top two bits differ -> overflow, clamp to -8192 or 8191
  function automatic dac_sample_t saturate(input logic signed [DAC_W:0] sum);
    if (sum[DAC_W] ^ sum[DAC_W-1])
      return {sum[DAC_W], {(DAC_W-1){~sum[DAC_W]}}};
    else
      return sum[DAC_W-1:0];
  endfunction

  assign sat_a_o = saturate(sum_a);
  assign sat_b_o = saturate(sum_b);

  ////////////////////////////////////////////////////////////////////////////
  // DAC code register
  ////////////////////////////////////////////////////////////////////////////

  // Keep MSB, invert the rest
  function automatic logic [DAC_W-1:0] dac_code(input dac_sample_t smp);
    return {smp[DAC_W-1], ~smp[DAC_W-2:0]};
  endfunction

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_code_a_o <= '0;
      dac_code_b_o <= '0;
    end else begin
      dac_code_a_o <= dac_code(sat_a_o);  // new sample every cycle
      dac_code_b_o <= dac_code(sat_b_o);
    end
  end

endmodule : dac_output_stage

`default_nettype wire

// ==== logic/pdm_modulator.sv ====
// First-order PDM outputs
// Accumulator carry per channel gives level ones per 256 cycles

`timescale 1ns/1ps
`default_nettype none

module pdm_modulator import analog_pkg::*; #(
  parameter int unsigned NUM_PDM = 4             // number of PDM channels
) (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,      // async, active low
  input  logic [NUM_PDM*PDM_W-1:0] pdm_level_i,  // packed levels, ch 0 low
  output logic [NUM_PDM-1:0]       pdm_o         // one bit per channel
);

  for (genvar k = 0; k < NUM_PDM; k++) begin : g_ch
    logic [PDM_W-1:0] acc;    // phase accumulator
    logic [PDM_W:0]   acc_nx; // carry plus next phase

    // Level added every cycle
    assign acc_nx = acc + pdm_level_i[k*PDM_W +: PDM_W];

    always_ff @(posedge adc_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        acc      <= '0;
        pdm_o[k] <= 1'b0;
      end else begin
        acc      <= acc_nx[PDM_W-1:0];
        pdm_o[k] <= acc_nx[PDM_W];    // carry out as density bit
      end
    end
  end : g_ch

endmodule : pdm_modulator

`default_nettype wire

// ==== test/tb_analog_top.sv ====
// Analog sample path testbench
// Table-driven checks of registers, ADC and DAC formats, loopback and PDM density

`timescale 1ns/1ps
`default_nettype none

module tb_analog_top import analog_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_PDM    = 4;
  localparam int ADC_N      = 8;   // ADC table entries
  localparam int DAC_N      = 10;  // DAC table entries
  localparam int APB_OPS    = 32;  // upper bound of APB transfers
  // Two cycles per table entry, DAC table used twice, two PDM windows, x2 margin
  localparam int WATCHDOG_NS =
    (2*ADC_N + 4*DAC_N + 3*APB_OPS + 2*256 + 16) * CLK_PERIOD * 2;

  logic               adc_clk;
  logic               rst_n_i;
  logic [APB_AW-1:0]  paddr_i;
  logic               psel_i, penable_i, pwrite_i;
  logic [31:0]        pwdata_i, prdata_o;
  logic               pready_o, pslverr_o;
  logic [ADC_W-1:0]   adc_raw_a_i, adc_raw_b_i;
  adc_sample_t        adc_a_o, adc_b_o;
  dac_sample_t        asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  logic [DAC_W-1:0]   dac_code_a_o, dac_code_b_o;
  logic [NUM_PDM-1:0] pdm_o;

  integer seed;
  int     pass_cnt, fail_cnt, fail_mark;
  int     pdm_cnt[NUM_PDM];                   // ones per channel in one window
  logic [15:0] adc_tab[ADC_N];                // raw ADC words
  int     asg_tab[DAC_N], pid_tab[DAC_N];     // generator and PID samples
  int     sat_a_tab[DAC_N], sat_b_tab[DAC_N]; // expected clamped sums

  analog_top #(.NUM_PDM(NUM_PDM)) u_dut (.*);

  always #(CLK_PERIOD/2) adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules and helpers
  ////////////////////////////////////////////////////////////////////////////

  // Negative slope to two's complement, MSB kept
  function automatic logic [15:0] adc_expect(input logic [15:0] raw);
    return raw ^ 16'h7FFF;
  endfunction

  function automatic int clamp_sum(input int a, input int b);
    int s;
    s = a + b;
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s;
  endfunction

  // Clamped sample back to DAC code
  function automatic logic [13:0] dac_expect(input int s);
    return 14'(s) ^ 14'h1FFF;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic test_done(input string name);
    $display("Test %s finished with %0d mismatches", name, fail_cnt - fail_mark);
    fail_mark = fail_cnt;
  endtask

  // Setup phase, then a single access phase with no wait states
  task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] data,
                          output logic [31:0] rdata, output logic err);
    @(negedge adc_clk);
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = data;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge adc_clk);
    penable_i = 1'b1;
    #1;
    check(pready_o, 1, "pready in access phase");
    rdata = prdata_o;                          // valid in access phase
    err   = pslverr_o;
    @(negedge adc_clk);                        // write landed on last edge
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic drive_dac(input int i);
    asg_a_i = 14'(asg_tab[i]);
    pid_a_i = 14'(pid_tab[i]);
    asg_b_i = 14'(asg_tab[i]);
    pid_b_i = 14'(pid_tab[DAC_N-1-i]);         // other pairing on channel B
  endtask

  task automatic count_pdm();
    for (int k = 0; k < NUM_PDM; k++)
      pdm_cnt[k] = 0;
    repeat (256) begin
      @(negedge adc_clk);
      for (int k = 0; k < NUM_PDM; k++)
        if (pdm_o[k])
          pdm_cnt[k]++;
    end
  endtask

  task automatic fill_tables();
    int lim[8] = '{8191, -8192, 8191, -8192, 4096, -4096, 8191, -8192};
    int add[8] = '{1, -1, 0, 0, 4095, -4096, 8191, -8192};
    adc_tab[0] = 16'h0000;
    adc_tab[1] = 16'hFFFF;
    adc_tab[2] = 16'h8000;
    adc_tab[3] = 16'h7FFF;
    adc_tab[4] = 16'h0001;
    for (int i = 5; i < ADC_N; i++)
      adc_tab[i] = 16'($random(seed));
    // Overflow both ways, exact limits, then random pairs
    for (int i = 0; i < DAC_N; i++) begin
      asg_tab[i] = (i < 8) ? lim[i] : $random(seed) % 8192;
      pid_tab[i] = (i < 8) ? add[i] : $random(seed) % 8192;
    end
    for (int i = 0; i < DAC_N; i++) begin
      sat_a_tab[i] = clamp_sum(asg_tab[i], pid_tab[i]);
      sat_b_tab[i] = clamp_sum(asg_tab[i], pid_tab[DAC_N-1-i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic        err;
    logic [7:0]  lvl[NUM_PDM];
    logic [7:0]  bad_addr[3];                  // unmapped offsets
    seed = 88;
    pass_cnt = 0;
    fail_cnt = 0;
    fail_mark = 0;
    adc_clk = 1'b0;
    rst_n_i = 1'b0;
    {paddr_i, psel_i, penable_i, pwrite_i, pwdata_i} = '0;
    {adc_raw_a_i, adc_raw_b_i} = '0;
    {asg_a_i, asg_b_i, pid_a_i, pid_b_i} = '0;
    fill_tables();
    repeat (2) @(negedge adc_clk);
    // Reset state, codes checked while reset still holds
    check(dac_code_a_o, 0, "DAC code A in reset");
    check(dac_code_b_o, 0, "DAC code B in reset");
    check($unsigned(adc_a_o), 0, "ADC A in reset");
    check($unsigned(adc_b_o), 0, "ADC B in reset");
    check(pslverr_o, 0, "pslverr in reset");
    rst_n_i = 1'b1;
    apb_xfer(REG_CTRL, 1'b0, 0, rd, err);
    check(rd, 0, "CTRL after reset");
    for (int k = 0; k < NUM_PDM; k++) begin
      apb_xfer(REG_PDM_BASE + 8'(4*k), 1'b0, 0, rd, err);
      check(rd, 0, $sformatf("PDM level %0d after reset", k));
    end
    count_pdm();
    for (int k = 0; k < NUM_PDM; k++)
      check(pdm_cnt[k], 0, $sformatf("pdm_o[%0d] ones after reset", k));
    test_done("reset_state");

    for (int i = 0; i < ADC_N; i++) begin
      @(negedge adc_clk);
      adc_raw_a_i = adc_tab[i];
      adc_raw_b_i = {adc_tab[i][7:0], adc_tab[i][15:8]};  // byte swap for B
      @(negedge adc_clk);
      check($unsigned(adc_a_o), adc_expect(adc_raw_a_i), $sformatf("ADC A entry %0d", i));
      check($unsigned(adc_b_o), adc_expect(adc_raw_b_i), $sformatf("ADC B entry %0d", i));
    end
    test_done("adc_conversion");

    for (int i = 0; i < DAC_N; i++) begin
      @(negedge adc_clk);
      drive_dac(i);
      @(negedge adc_clk);
      check(dac_code_a_o, dac_expect(sat_a_tab[i]), $sformatf("DAC A entry %0d", i));
      check(dac_code_b_o, dac_expect(sat_b_tab[i]), $sformatf("DAC B entry %0d", i));
    end
    test_done("dac_saturation");

    apb_xfer(REG_CTRL, 1'b1, 32'hFFFF_FFFF, rd, err);
    check(err, 0, "CTRL write error flag");
    apb_xfer(REG_CTRL, 1'b0, 0, rd, err);
    check(rd, 1, "CTRL readback");             // only bit 0 is stored
    for (int i = 0; i < DAC_N; i++) begin
      @(negedge adc_clk);
      drive_dac(i);
      @(negedge adc_clk);
      // Zero padded, not sign extended
      check($unsigned(adc_a_o), {2'b00, 14'(sat_a_tab[i])}, $sformatf("loop A entry %0d", i));
      check($unsigned(adc_b_o), {2'b00, 14'(sat_b_tab[i])}, $sformatf("loop B entry %0d", i));
    end
    apb_xfer(REG_CTRL, 1'b1, 32'h0, rd, err);
    @(negedge adc_clk);
    adc_raw_a_i = 16'h1234;
    adc_raw_b_i = 16'hC0DE;
    @(negedge adc_clk);
    check($unsigned(adc_a_o), adc_expect(16'h1234), "ADC A after loop off");
    check($unsigned(adc_b_o), adc_expect(16'hC0DE), "ADC B after loop off");
    test_done("digital_loopback");

    for (int k = 0; k < NUM_PDM; k++) begin
      apb_xfer(REG_PDM_BASE + 8'(4*k), 1'b1, {24'hA5A5A5, 8'(8'h3C + 8'h11*k)}, rd, err);
      check(err, 0, $sformatf("PDM %0d write error flag", k));
    end
    bad_addr = '{REG_PDM_BASE + 8'(4*NUM_PDM), 8'h06, 8'hFC};
    foreach (bad_addr[j]) begin
      apb_xfer(bad_addr[j], 1'b1, 32'hFFFF_FFFF, rd, err);
      check(err, 1, $sformatf("pslverr on write to %h", bad_addr[j]));
      apb_xfer(bad_addr[j], 1'b0, 0, rd, err);
      check(err, 1, $sformatf("pslverr on read of %h", bad_addr[j]));
      check(rd, 0, $sformatf("read data of %h", bad_addr[j]));
    end
    // Each level kept its own byte through the unmapped writes
    for (int k = 0; k < NUM_PDM; k++) begin
      apb_xfer(REG_PDM_BASE + 8'(4*k), 1'b0, 0, rd, err);
      check(rd, 8'h3C + 8'h11*k, $sformatf("PDM %0d readback", k));  // upper bits zero
    end
    test_done("registers_errors");

    lvl = '{8'd0, 8'd1, 8'd128, 8'd255};
    for (int k = 0; k < NUM_PDM; k++)
      apb_xfer(REG_PDM_BASE + 8'(4*k), 1'b1, lvl[k], rd, err);
    repeat (4) @(negedge adc_clk);            // let the new levels settle
    count_pdm();
    for (int k = 0; k < NUM_PDM; k++)
      check(pdm_cnt[k], lvl[k], $sformatf("pdm_o[%0d] ones per window", k));
    test_done("pdm_density");

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : tb_analog_top

`default_nettype wire
